// File: Makefile
# Verilator build and run for the data-side OBI adapter testbench

TOP = tb_data_obi

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f compile.f -Mdir obj_dir

# Pass only when the testbench reports no errors
run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

// File: compile.f
obi_pkg.sv
obi_rchk_check.sv
obi_integrity_fifo.sv
data_obi_interface.sv
data_obi_asserts.sv
tb_data_obi.sv

// File: data_obi_asserts.sv
// Bound checks on the data-side OBI adapter
// Request parity, response valid passthrough and alert on response faults

module data_obi_asserts (
  input logic                    clk,
  input logic                    rst_n_i,
  input logic                    obi_req_i,
  input logic                    obi_reqpar_i,
  input obi_pkg::obi_r_valid_t   obi_r_valid_i,
  input logic                    resp_valid_i,
  input obi_pkg::obi_data_resp_t resp_i,
  input logic                    gntpar_err_resp_i,
  input logic                    alert_major_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Request parity is always the inverse of req
  reqpar_inverse_a : assert property (@(posedge clk) disable iff (!rst_n_i)
    obi_reqpar_i == !obi_req_i)
    else $error("obi_reqpar_o is not the inverse of obi_req_o");

  // Response valid is a straight copy of rvalid
  resp_valid_a : assert property (@(posedge clk) disable iff (!rst_n_i)
    resp_valid_i == obi_r_valid_i.rvalid)
    else $error("resp_valid_o differs from rvalid");

  // Stored grant errors already raised the alert in their grant cycle
  integrity_alert_a : assert property (@(posedge clk) disable iff (!rst_n_i)
    resp_valid_i && resp_i.integrity_err && !gntpar_err_resp_i |-> alert_major_i)
    else $error("integrity_err on a valid response without alert_major_o");

endmodule

bind data_obi_interface data_obi_asserts data_obi_asserts_i (
  .clk               (clk),
  .rst_n_i           (rst_n_i),
  .obi_req_i         (obi_req_o),
  .obi_reqpar_i      (obi_reqpar_o),
  .obi_r_valid_i     (obi_r_valid_i),
  .resp_valid_i      (resp_valid_o),
  .resp_i            (resp_o),
  .gntpar_err_resp_i (gntpar_err_resp),
  .alert_major_i     (alert_major_o)
);

// File: data_obi_interface.sv
// Data-side OBI adapter
// Maps transaction requests onto the OBI A channel with achk,
// passes R channel responses back with integrity flags and
// raises a major alert on parity, checksum or protocol faults

module data_obi_interface (
  input  logic                    clk,
  input  logic                    rst_n_i,

  // Transaction request
  input  logic                    trans_valid_i,
  output logic                    trans_ready_o,
  input  obi_pkg::obi_data_req_t  trans_i,

  // Transaction response, consumer always ready
  output logic                    resp_valid_o,
  output obi_pkg::obi_data_resp_t resp_o,

  output logic                    alert_major_o,

  input  obi_pkg::xsecure_ctrl_t  xsecure_ctrl_i,

  // OBI A channel
  output logic                    obi_req_o,
  output logic                    obi_reqpar_o,
  output obi_pkg::obi_data_req_t  obi_a_o,
  input  obi_pkg::obi_a_resp_t    obi_a_resp_i,

  // OBI R channel
  input  obi_pkg::obi_r_valid_t   obi_r_valid_i,
  input  obi_pkg::obi_data_resp_t obi_r_i
);

  // Immediate parity faults
  logic gntpar_err;
  logic rvalidpar_err;

  // Flags of the transfer being answered
  logic gntpar_err_resp;
  logic integrity_resp;
  logic rchk_err_resp;

  // rvalid with nothing outstanding
  logic protocol_err;

  //////////////////////////////////////////////////////////////////////
  // A channel
  //////////////////////////////////////////////////////////////////////

  // Source holds the request stable until granted
  assign obi_req_o     = trans_valid_i;
  assign obi_reqpar_o  = !trans_valid_i;
  assign trans_ready_o = obi_a_resp_i.gnt;

  always_comb begin
    obi_a_o = trans_i;
    // Even parity per wdata byte
    obi_a_o.achk[11] = ^trans_i.wdata[31:24];
    obi_a_o.achk[10] = ^trans_i.wdata[23:16];
    obi_a_o.achk[9]  = ^trans_i.wdata[15:8];
    obi_a_o.achk[8]  = ^trans_i.wdata[7:0];
    // atop is tied to zero
    obi_a_o.achk[7]  = ^6'b0;
    // Odd parity on attributes
    obi_a_o.achk[6]  = ~^trans_i.dbg;
    obi_a_o.achk[5]  = ~^{trans_i.be, trans_i.we};
    obi_a_o.achk[4]  = ~^{trans_i.prot, trans_i.memtype};
    // Even parity per address byte
    obi_a_o.achk[3]  = ^trans_i.addr[31:24];
    obi_a_o.achk[2]  = ^trans_i.addr[23:16];
    obi_a_o.achk[1]  = ^trans_i.addr[15:8];
    obi_a_o.achk[0]  = ^trans_i.addr[7:0];
  end

  //////////////////////////////////////////////////////////////////////
  // R channel
  //////////////////////////////////////////////////////////////////////

  assign resp_valid_o = obi_r_valid_i.rvalid;

  always_comb begin
    resp_o               = obi_r_i;
    resp_o.integrity_err = rvalidpar_err || gntpar_err_resp || rchk_err_resp;
    resp_o.integrity     = integrity_resp;
  end

  //////////////////////////////////////////////////////////////////////
  // Integrity checks
  //////////////////////////////////////////////////////////////////////

  // Parity is the inverse, so equality is an error
  assign gntpar_err    = (obi_a_resp_i.gnt == obi_a_resp_i.gntpar);
  assign rvalidpar_err = (obi_r_valid_i.rvalid == obi_r_valid_i.rvalidpar);

  obi_integrity_fifo integrity_fifo_i (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .gntpar_err_i      (gntpar_err),
    .trans_integrity_i (trans_i.integrity),
    .xsecure_ctrl_i    (xsecure_ctrl_i),
    .obi_req_i         (obi_req_o),
    .obi_gnt_i         (obi_a_resp_i.gnt),
    .obi_rvalid_i      (obi_r_valid_i.rvalid),
    .obi_resp_i        (obi_r_i),
    .gntpar_err_resp_o (gntpar_err_resp),
    .integrity_resp_o  (integrity_resp),
    .rchk_err_resp_o   (rchk_err_resp),
    .protocol_err_o    (protocol_err)
  );

  // Any fault raises the alert in the cycle it is seen
  assign alert_major_o = gntpar_err || rvalidpar_err || rchk_err_resp || protocol_err;

endmodule

// File: obi_integrity_fifo.sv
// OBI integrity FIFO
// Captures per-transfer flags at grant time and presents them when
// the matching in-order response returns. Also qualifies the rchk
// check and flags responses that arrive with nothing outstanding

module obi_integrity_fifo (
  input  logic                    clk,
  input  logic                    rst_n_i,

  // Grant-time properties
  input  logic                    gntpar_err_i,
  input  logic                    trans_integrity_i,

  input  obi_pkg::xsecure_ctrl_t  xsecure_ctrl_i,

  // OBI handshake and response payload
  input  logic                    obi_req_i,
  input  logic                    obi_gnt_i,
  input  logic                    obi_rvalid_i,
  input  obi_pkg::obi_data_resp_t obi_resp_i,

  // Response-time flags
  output logic                    gntpar_err_resp_o,
  output logic                    integrity_resp_o,
  output logic                    rchk_err_resp_o,
  output logic                    protocol_err_o
);

  // Flag storage has no reset
  obi_pkg::obi_integrity_entry_t fifo_q [obi_pkg::MAX_OUTSTANDING];

  obi_pkg::fifo_ptr_t        wptr_q;
  obi_pkg::fifo_ptr_t        rptr_q;
  obi_pkg::outstanding_cnt_t cnt_q;

  obi_pkg::obi_integrity_entry_t wr_entry;
  obi_pkg::obi_integrity_entry_t head;

  logic empty;
  logic full;
  logic push;
  logic pop;
  logic head_valid;
  logic rchk_err;

  // Circular pointer advance
  function automatic obi_pkg::fifo_ptr_t ptr_inc(obi_pkg::fifo_ptr_t ptr);
    obi_pkg::fifo_ptr_t nxt;
    if (ptr == obi_pkg::fifo_ptr_t'(obi_pkg::MAX_OUTSTANDING - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Push and pop control
  //////////////////////////////////////////////////////////////////////

  assign empty = (cnt_q == '0);
  assign full  = (cnt_q == obi_pkg::outstanding_cnt_t'(obi_pkg::MAX_OUTSTANDING));

  // Granted transfer, kept in bounds when full and not draining
  assign push = obi_req_i && obi_gnt_i && (!full || pop);

  // Only a response that matches an outstanding transfer pops
  assign pop = obi_rvalid_i && !empty;

  // Entry captured at the grant
  assign wr_entry.gntpar_err = gntpar_err_i;
  assign wr_entry.integrity  = trans_integrity_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (pop) begin
        rptr_q <= ptr_inc(rptr_q);
      end
      // Occupancy holds on simultaneous push and pop
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_q[wptr_q] <= wr_entry;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////////////////////////

  // Head is read combinationally
  assign head       = fifo_q[rptr_q];
  assign head_valid = obi_rvalid_i && !empty;

  obi_rchk_check rchk_check_i (
    .resp_i     (obi_resp_i),
    .rchk_err_o (rchk_err)
  );

  assign gntpar_err_resp_o = head_valid && head.gntpar_err;
  assign integrity_resp_o  = head_valid && head.integrity;

  // rchk only counts for integrity transfers with checking enabled
  assign rchk_err_resp_o = head_valid && head.integrity &&
                           xsecure_ctrl_i.rchk_en && rchk_err;

  // Response with no transfer outstanding
  assign protocol_err_o = obi_rvalid_i && empty;

endmodule

// File: obi_pkg.sv
// OBI data-side adapter package
// Shared field widths, A and R channel payload structs,
// security control and integrity FIFO sizing

package obi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Integrity FIFO sizing
  //////////////////////////////////////////////////////////////////////

  // Transfers in flight between grant and response
  localparam int unsigned MAX_OUTSTANDING = 2;

  // Occupancy runs from 0 up to MAX_OUTSTANDING inclusive
  localparam int unsigned OUTSTANDING_CNT_W = $clog2(MAX_OUTSTANDING + 1);

  // Read and write pointer width, never below one bit
  localparam int unsigned FIFO_PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;

  //////////////////////////////////////////////////////////////////////
  // Field widths
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;
  typedef logic [2:0]  prot_t;
  typedef logic [1:0]  memtype_t;

  // Address phase checksum over the A channel payload
  typedef logic [11:0] achk_t;
  // Response checksum over rdata, err and exokay
  typedef logic [4:0]  rchk_t;

  typedef logic [OUTSTANDING_CNT_W-1:0] outstanding_cnt_t;
  typedef logic [FIFO_PTR_W-1:0]        fifo_ptr_t;

  //////////////////////////////////////////////////////////////////////
  // OBI payloads
  //////////////////////////////////////////////////////////////////////

  // A channel payload
  typedef struct packed {
    addr_t    addr;
    logic     we;
    be_t      be;
    data_t    wdata;
    prot_t    prot;
    memtype_t memtype;
    logic     dbg;
    logic     integrity;
    achk_t    achk;      // driven by the adapter
  } obi_data_req_t;

  // R channel payload plus the adapter's integrity flags
  typedef struct packed {
    data_t rdata;
    logic  err;
    logic  exokay;
    rchk_t rchk;
    logic  integrity_err;  // set by the adapter
    logic  integrity;      // set by the adapter
  } obi_data_resp_t;

  // Grant with its parity
  typedef struct packed {
    logic gnt;
    logic gntpar;
  } obi_a_resp_t;

  // Response valid with its parity
  typedef struct packed {
    logic rvalid;
    logic rvalidpar;
  } obi_r_valid_t;

  // Security control
  typedef struct packed {
    logic rchk_en;
  } xsecure_ctrl_t;

  // Per-transfer flags captured at grant time
  typedef struct packed {
    logic gntpar_err;
    logic integrity;
  } obi_integrity_entry_t;

endpackage

// File: obi_rchk_check.sv
// OBI response checksum checker
// Recomputes rchk from rdata, err and exokay and flags a mismatch
// with the received value. Purely combinational

module obi_rchk_check (
  input  obi_pkg::obi_data_resp_t resp_i,
  output logic                    rchk_err_o
);

  obi_pkg::rchk_t rchk_exp;

  //////////////////////////////////////////////////////////////////////
  // Expected checksum
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Odd parity over the status bits
    rchk_exp[4] = ~^{resp_i.err, resp_i.exokay};
    // Even parity per rdata byte
    rchk_exp[3] = ^resp_i.rdata[31:24];
    rchk_exp[2] = ^resp_i.rdata[23:16];
    rchk_exp[1] = ^resp_i.rdata[15:8];
    rchk_exp[0] = ^resp_i.rdata[7:0];
  end

  // Raw mismatch
  // Qualified by rvalid, integrity and rchk_en downstream
  assign rchk_err_o = (rchk_exp != resp_i.rchk);

endmodule

// File: tb_data_obi.sv
// Testbench for the data-side OBI adapter
// Plays the OBI slave and runs directed tests on the A and R channels,
// the parity checks, the rchk check and the protocol error

module tb_data_obi;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned TIMEOUT_CYCLES = 400;

  logic                    clk;
  logic                    rst_n_i;
  logic                    trans_valid_i;
  logic                    trans_ready_o;
  obi_pkg::obi_data_req_t  trans_i;
  logic                    resp_valid_o;
  obi_pkg::obi_data_resp_t resp_o;
  logic                    alert_major_o;
  obi_pkg::xsecure_ctrl_t  xsecure_ctrl_i;
  logic                    obi_req_o;
  logic                    obi_reqpar_o;
  obi_pkg::obi_data_req_t  obi_a_o;
  obi_pkg::obi_a_resp_t    obi_a_resp_i;
  obi_pkg::obi_r_valid_t   obi_r_valid_i;
  obi_pkg::obi_data_resp_t obi_r_i;

  int unsigned cycle_cnt = 0;

  data_obi_interface data_obi_interface_i (.*);

  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Failure handling and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "Stopped at first failure");
  endtask

  // Guard against a hung run
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run("Timeout: the tests did not finish within the cycle limit");
    end
  end

  task automatic check_req(input string name, input obi_pkg::obi_data_req_t got,
                           input obi_pkg::obi_data_req_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input obi_pkg::obi_data_resp_t got,
                            input obi_pkg::obi_data_resp_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checksum model and stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Address phase checksum with atop at zero
  function automatic obi_pkg::achk_t calc_achk(input obi_pkg::obi_data_req_t req);
    obi_pkg::achk_t chk;
    // Even parity per byte of wdata and addr
    for (int b = 0; b < 4; b++) begin
      chk[8 + b] = ^req.wdata[8*b +: 8];
      chk[b]     = ^req.addr[8*b +: 8];
    end
    chk[7] = 1'b0;
    // Odd parity on the attribute groups
    chk[6] = !req.dbg;
    chk[5] = !(^{req.be, req.we});
    chk[4] = !(^{req.prot, req.memtype});
    return chk;
  endfunction

  // Response checksum as the slave builds it
  function automatic obi_pkg::rchk_t calc_rchk(input obi_pkg::data_t rdata, input logic err,
                                               input logic exokay);
    obi_pkg::rchk_t chk;
    for (int b = 0; b < 4; b++) begin
      chk[b] = ^rdata[8*b +: 8];
    end
    chk[4] = !(err ^ exokay);
    return chk;
  endfunction

  // Random payload with a junk achk for the DUT to replace
  function automatic obi_pkg::obi_data_req_t random_req(input logic we, input logic integrity);
    obi_pkg::obi_data_req_t req;
    req.addr      = obi_pkg::addr_t'($urandom);
    req.we        = we;
    req.be        = obi_pkg::be_t'($urandom);
    req.wdata     = obi_pkg::data_t'($urandom);
    req.prot      = obi_pkg::prot_t'($urandom);
    req.memtype   = obi_pkg::memtype_t'($urandom);
    req.dbg       = 1'($urandom);
    req.integrity = integrity;
    req.achk      = obi_pkg::achk_t'($urandom);
    return req;
  endfunction

  // Slave idle with correct parity and no request
  task automatic drive_idle();
    trans_valid_i = 1'b0;
    obi_a_resp_i  = '{gnt: 1'b0, gntpar: 1'b1};
    obi_r_valid_i = '{rvalid: 1'b0, rvalidpar: 1'b1};
    obi_r_i       = '0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Slave side transfers
  //////////////////////////////////////////////////////////////////////

  // Request held until granted after hold_cycles
  task automatic send_request(input obi_pkg::obi_data_req_t req, input int hold_cycles,
                              input logic bad_gntpar);
    obi_pkg::obi_data_req_t exp_a;
    int   waited;
    logic gnt;
    exp_a      = req;
    exp_a.achk = calc_achk(req);
    waited     = 0;
    do begin
      @(negedge clk);
      drive_idle();
      gnt                 = (waited >= hold_cycles);
      trans_valid_i       = 1'b1;
      trans_i             = req;
      obi_a_resp_i.gnt    = gnt;
      // Bad parity only in the grant cycle
      obi_a_resp_i.gntpar = (bad_gntpar && gnt) ? 1'b1 : !gnt;
      #40;
      // Payload must stay stable while the grant is withheld
      check_bit("obi_req_o", obi_req_o, 1'b1);
      check_bit("obi_reqpar_o", obi_reqpar_o, 1'b0);
      check_bit("trans_ready_o", trans_ready_o, gnt);
      check_req("obi_a_o", obi_a_o, exp_a);
      check_bit("alert_major_o", alert_major_o, bad_gntpar && gnt);
      waited++;
    end while (!trans_ready_o);
  endtask

  // One response cycle, expected flags supplied by the caller
  task automatic send_response(input obi_pkg::data_t rdata, input logic err,
                               input logic exokay, input logic corrupt_rchk,
                               input logic bad_rvalidpar, input logic exp_integrity,
                               input logic exp_integrity_err, input logic exp_alert);
    obi_pkg::obi_data_resp_t resp;
    obi_pkg::obi_data_resp_t exp_resp;
    resp        = '0;
    resp.rdata  = rdata;
    resp.err    = err;
    resp.exokay = exokay;
    resp.rchk   = calc_rchk(rdata, err, exokay);
    // Flip one bit to break the checksum
    if (corrupt_rchk) begin
      resp.rchk[0] = !resp.rchk[0];
    end
    exp_resp               = resp;
    exp_resp.integrity_err = exp_integrity_err;
    exp_resp.integrity     = exp_integrity;
    @(negedge clk);
    drive_idle();
    obi_r_valid_i = '{rvalid: 1'b1, rvalidpar: bad_rvalidpar};
    obi_r_i       = resp;
    #40;
    // No request while the response returns
    check_bit("obi_req_o", obi_req_o, 1'b0);
    check_bit("obi_reqpar_o", obi_reqpar_o, 1'b1);
    check_bit("resp_valid_o", resp_valid_o, 1'b1);
    check_resp("resp_o", resp_o, exp_resp);
    check_bit("alert_major_o", alert_major_o, exp_alert);
  endtask

  // One idle cycle to change the rchk enable
  task automatic set_rchk_en(input logic en);
    @(negedge clk);
    drive_idle();
    xsecure_ctrl_i.rchk_en = en;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_unexpected_response();
    // Nothing outstanding since reset
    send_response($urandom, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
  endtask

  task automatic test_write_read();
    send_request(random_req(1'b1, 1'b0), 0, 1'b0);
    send_response($urandom, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    send_request(random_req(1'b0, 1'b1), 1, 1'b0);
    send_response($urandom, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
  endtask

  task automatic test_bad_gntpar();
    // Grant error shows up again on its own response only
    send_request(random_req(1'b1, 1'b0), 0, 1'b1);
    send_response($urandom, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    send_request(random_req(1'b0, 1'b0), 0, 1'b0);
    send_response($urandom, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic test_bad_rvalidpar();
    send_request(random_req(1'b0, 1'b0), 0, 1'b0);
    send_response($urandom, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1);
  endtask

  task automatic test_corrupt_rchk();
    send_request(random_req(1'b0, 1'b1), 0, 1'b0);
    send_response($urandom, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1);
    // Mismatch ignored with integrity clear
    send_request(random_req(1'b0, 1'b0), 0, 1'b0);
    send_response($urandom, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    // Checking disabled
    set_rchk_en(1'b0);
    send_request(random_req(1'b0, 1'b1), 0, 1'b0);
    send_response($urandom, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
    set_rchk_en(1'b1);
  endtask

  task automatic test_back_to_back();
    send_request(random_req(1'b1, 1'b1), 0, 1'b0);
    // Second request waits two cycles for its grant
    send_request(random_req(1'b0, 1'b0), 2, 1'b1);
    // Responses in order, each with its own stored flags
    send_response($urandom, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    send_response($urandom, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
  endtask

  initial begin
    void'($urandom(32'hf5e4_ae57));
    clk            = 1'b0;
    rst_n_i        = 1'b0;
    trans_i        = '0;
    xsecure_ctrl_i = '{rchk_en: 1'b1};
    drive_idle();
    repeat (4) @(negedge clk);
    rst_n_i = 1'b1;
    test_unexpected_response();
    test_write_read();
    test_bad_gntpar();
    test_bad_rvalidpar();
    test_corrupt_rchk();
    test_back_to_back();
    @(negedge clk);
    drive_idle();
    $display("No errors");
    $finish;
  end

endmodule
